//--- design/gpmc_defines.svh
// Sizing of the host-to-FPGA page bridge.
// The page count is a power of two and a frame must fit in one page
// after the transfer offset. Word addresses count 16-bit bus words.

`ifndef GPMC_DEFINES_SVH
`define GPMC_DEFINES_SVH

// Log2 of the number of pages in the block RAM
`define GPMC_PTR_WIDTH 2

// Word-address bits inside one page, taken from bus bits 1 and up
`define GPMC_ADDR_WIDTH 10

// Word address of a frame's first word, which holds the frame length
`define GPMC_XFER_OFFSET 2

// Width of the host data bus
`define GPMC_DATA_WIDTH 16

// Depth of the output frame FIFO as a power of two
`define GPMC_FIFO_DEPTH_LOG2 4

`endif

//--- design/gpmc_pkg.sv
// Shared types of the page bridge.
// Widths follow the sizing macros of the defines header.

`include "gpmc_defines.svh"

package gpmc_pkg;

    // One word of the host data bus
    typedef logic [`GPMC_DATA_WIDTH-1:0] em_data_t;

    // Word address inside a page, numbered like the bus address pins
    typedef logic [`GPMC_ADDR_WIDTH:1] em_addr_t;

    // Stream word: bit 17 marks end of frame, bit 16 marks start of frame
    typedef logic [`GPMC_DATA_WIDTH+1:0] frame_word_t;

    // Page pointer, the top bit is the wrap bit
    typedef logic [`GPMC_PTR_WIDTH:0] page_ptr_t;

    // Host-side machine, waiting for a length word or filling a page
    typedef enum logic {
        START,
        FILL
    } gpmc_state_e;

    // Emptier machine in the system clock domain
    typedef enum logic [1:0] {
        CLAIM = 2'd0,
        PRE   = 2'd1,
        EMPTY = 2'd2
    } fifo_state_e;

endpackage

//--- design/ram_2port.sv
// True dual-port RAM, each port on its own clock with its own enable.
// Reads are registered and return the old word when the same port writes.
// Contents are not reset.

`timescale 1ns/1ns

module ram_2port #(
    parameter int DWIDTH = 18,
    parameter int AWIDTH = 12
) (
    input  logic              clka_i,
    input  logic              ena_i,
    input  logic              wea_i,
    input  logic [AWIDTH-1:0] addra_i,
    input  logic [DWIDTH-1:0] dia_i,
    output logic [DWIDTH-1:0] doa_o,
    input  logic              clkb_i,
    input  logic              enb_i,
    input  logic              web_i,
    input  logic [AWIDTH-1:0] addrb_i,
    input  logic [DWIDTH-1:0] dib_i,
    output logic [DWIDTH-1:0] dob_o
);

    logic [DWIDTH-1:0] mem [0:(1 << AWIDTH)-1];

    // Port A, read before write
    always @(posedge clka_i) begin
        if (ena_i) begin
            doa_o <= mem[addra_i];
            if (wea_i)
                mem[addra_i] <= dia_i;
        end
    end

    // Port B, same behaviour on the second clock
    always @(posedge clkb_i) begin
        if (enb_i) begin
            dob_o <= mem[addrb_i];
            if (web_i)
                mem[addrb_i] <= dib_i;
        end
    end

endmodule

//--- design/cross_clock_reader.sv
// Carries a slowly changing multi-bit value into the clk domain.
// The value must stay stable for at least three clk cycles after a change,
// otherwise it may never be passed.

`timescale 1ns/1ns

module cross_clock_reader #(
    parameter int WIDTH = $bits(gpmc_pkg::page_ptr_t)
) (
    input  logic             clk,
    input  logic             arst,
    input  logic [WIDTH-1:0] in_i,
    output logic [WIDTH-1:0] out_o
);

    // Two sampling flops, the second one is the older sample
    logic [WIDTH-1:0] sample_new;
    logic [WIDTH-1:0] sample_old;

    always_ff @(posedge clk) begin
        if (arst) begin
            sample_new <= '0;
            sample_old <= '0;
            out_o      <= '0;
        end else begin
            sample_new <= in_i;
            sample_old <= sample_new;
            // A value caught in mid-change shows up in only one sample
            if (sample_new == sample_old)
                out_o <= sample_old;
        end
    end

endmodule

//--- design/gpmc_to_fifo.sv
// Host writes frames into RAM pages on the falling edge of EM_CLK and the
// pages are emptied in order onto an 18-bit stream in the clk domain.
// The host side is reset only on EM_CLK falling edges while arst is high.
// A frame length of zero or beyond one page is not supported.
// clear_i drops every page already committed but not yet emptied.

`timescale 1ns/1ns
`include "gpmc_defines.svh"

module gpmc_to_fifo (
    input  gpmc_pkg::em_data_t    em_d_i,
    input  gpmc_pkg::em_addr_t    em_a_i,
    input  logic                  em_clk_i,
    input  logic                  em_we_i,
    input  logic                  clk,
    input  logic                  arst,
    input  logic                  clear_i,
    output gpmc_pkg::frame_word_t data_o,
    output logic                  src_rdy_o,
    input  logic                  dst_rdy_i,
    output logic                  have_space_o
);

    localparam int PTR_W = `GPMC_PTR_WIDTH;
    localparam int RAM_AW = `GPMC_PTR_WIDTH + `GPMC_ADDR_WIDTH;
    localparam gpmc_pkg::em_addr_t XFER_ADDR = gpmc_pkg::em_addr_t'(`GPMC_XFER_OFFSET);
    // Toggling the wrap bit turns "same page" into "one full lap ahead"
    localparam gpmc_pkg::page_ptr_t WRAP_BIT = gpmc_pkg::page_ptr_t'(1 << PTR_W);

    // ----------------------------------------
    // Host side, falling edge of EM_CLK
    // ----------------------------------------

    gpmc_pkg::gpmc_state_e gpmc_state;
    gpmc_pkg::em_data_t    frame_len;
    gpmc_pkg::em_addr_t    last_addr;
    gpmc_pkg::page_ptr_t   gpmc_ptr;
    gpmc_pkg::page_ptr_t   next_gpmc_ptr;
    gpmc_pkg::frame_word_t wr_word;
    logic                  wr_sof;
    logic                  wr_eof;
    logic                  em_clk_n;

    // Length counts 32-bit units, so the frame spans twice as many bus words
    assign last_addr = gpmc_pkg::em_addr_t'({frame_len[`GPMC_ADDR_WIDTH-2:0], 1'b0})
                     + XFER_ADDR - 1'b1;

    // The length word opens a frame, a frame never ends on its first word
    assign wr_sof = (gpmc_state == gpmc_pkg::START) && (em_a_i == XFER_ADDR);
    assign wr_eof = (gpmc_state == gpmc_pkg::FILL) && (em_a_i == last_addr);
    assign wr_word = {wr_eof, wr_sof, em_d_i};

    always_ff @(negedge em_clk_i) begin
        if (arst) begin
            gpmc_state    <= gpmc_pkg::START;
            gpmc_ptr      <= '0;
            next_gpmc_ptr <= '0;
        end else if (em_we_i) begin
            case (gpmc_state)
                gpmc_pkg::START: begin
                    // Writes outside the transfer offset are ignored here
                    if (wr_sof) begin
                        gpmc_state    <= gpmc_pkg::FILL;
                        next_gpmc_ptr <= gpmc_ptr + 1'b1;
                    end
                end
                gpmc_pkg::FILL: begin
                    // The last word commits the page to the emptier
                    if (wr_eof) begin
                        gpmc_state <= gpmc_pkg::START;
                        gpmc_ptr   <= next_gpmc_ptr;
                    end
                end
                default: gpmc_state <= gpmc_pkg::START;
            endcase
        end
    end

    // Frame length is captured from the length word itself
    always_ff @(negedge em_clk_i) begin
        if (em_we_i && wr_sof)
            frame_len <= em_d_i;
    end

    // Port A runs on the inverted strobe so each write lands on its own falling edge
    assign em_clk_n = ~em_clk_i;

    // ----------------------------------------
    // Pointer crossing into clk
    // ----------------------------------------

    gpmc_pkg::page_ptr_t safe_gpmc_ptr;
    gpmc_pkg::page_ptr_t safe_next_gpmc_ptr;
    gpmc_pkg::page_ptr_t fifo_ptr;
    logic                page_ready;

    // Committed pages
    cross_clock_reader #(
        .WIDTH($bits(gpmc_pkg::page_ptr_t))
    ) read_gpmc_ptr (
        .clk   (clk),
        .arst  (arst),
        .in_i  (gpmc_ptr),
        .out_o (safe_gpmc_ptr)
    );

    // Page the host is filling or will fill next
    cross_clock_reader #(
        .WIDTH($bits(gpmc_pkg::page_ptr_t))
    ) read_next_gpmc_ptr (
        .clk   (clk),
        .arst  (arst),
        .in_i  (next_gpmc_ptr),
        .out_o (safe_next_gpmc_ptr)
    );

    // Some page is committed while the two pointers differ
    assign page_ready = (safe_gpmc_ptr != fifo_ptr);

    // Space is gone once the host page in use is a full lap ahead of the emptier
    always_ff @(posedge clk) begin
        if (arst || clear_i)
            have_space_o <= 1'b0;
        else
            have_space_o <= ((fifo_ptr ^ WRAP_BIT) != safe_next_gpmc_ptr);
    end

    // ----------------------------------------
    // Page emptier
    // ----------------------------------------

    gpmc_pkg::fifo_state_e fifo_state;
    gpmc_pkg::em_addr_t    counter;
    logic                  rd_enable;

    always_ff @(posedge clk) begin
        if (arst) begin
            fifo_state <= gpmc_pkg::CLAIM;
            fifo_ptr   <= '0;
            counter    <= XFER_ADDR;
        end else if (clear_i) begin
            // Catch up with the host so pending pages are discarded
            fifo_state <= gpmc_pkg::CLAIM;
            fifo_ptr   <= safe_gpmc_ptr;
            counter    <= XFER_ADDR;
        end else begin
            case (fifo_state)
                gpmc_pkg::CLAIM: begin
                    // The RAM keeps reading the first word of the current page
                    if (page_ready && data_o[16])
                        fifo_state <= gpmc_pkg::PRE;
                    counter <= XFER_ADDR;
                end
                gpmc_pkg::PRE: begin
                    // The first word is on the output, start reading the second
                    fifo_state <= gpmc_pkg::EMPTY;
                    counter    <= counter + 1'b1;
                end
                gpmc_pkg::EMPTY: begin
                    if (dst_rdy_i) begin
                        if (data_o[17]) begin
                            fifo_state <= gpmc_pkg::CLAIM;
                            fifo_ptr   <= fifo_ptr + 1'b1;
                            counter    <= XFER_ADDR;
                        end else begin
                            counter <= counter + 1'b1;
                        end
                    end
                end
                default: fifo_state <= gpmc_pkg::CLAIM;
            endcase
        end
    end

    // Read output holds its word while the consumer stalls
    assign rd_enable = (fifo_state != gpmc_pkg::EMPTY) || dst_rdy_i;
    assign src_rdy_o = (fifo_state == gpmc_pkg::EMPTY);

    ram_2port #(
        .DWIDTH($bits(gpmc_pkg::frame_word_t)),
        .AWIDTH(RAM_AW)
    ) page_ram (
        .clka_i  (em_clk_n),
        .ena_i   (1'b1),
        .wea_i   (em_we_i),
        .addra_i ({gpmc_ptr[PTR_W-1:0], em_a_i}),
        .dia_i   (wr_word),
        .doa_o   (),
        .clkb_i  (clk),
        .enb_i   (rd_enable),
        .web_i   (1'b0),
        .addrb_i ({fifo_ptr[PTR_W-1:0], counter}),
        .dib_i   ('1),
        .dob_o   (data_o)
    );

endmodule

//--- design/frame_fifo.sv
// Small synchronous FIFO of stream words with ready/ready handshakes.
// A word accepted at the input shows at the output on the next cycle.
// Contents are not cleared, only the pointers and the count.

`timescale 1ns/1ns

module frame_fifo #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  arst,
    input  logic                  clear_i,
    input  gpmc_pkg::frame_word_t data_i,
    input  logic                  src_rdy_i,
    output logic                  dst_rdy_o,
    output gpmc_pkg::frame_word_t data_o,
    output logic                  src_rdy_o,
    input  logic                  dst_rdy_i
);

    localparam int DEPTH = 1 << DEPTH_LOG2;
    // Count value with every slot in use
    localparam logic [DEPTH_LOG2:0] FULL_COUNT = {1'b1, {DEPTH_LOG2{1'b0}}};

    gpmc_pkg::frame_word_t   mem [0:DEPTH-1];
    logic [DEPTH_LOG2-1:0]   wr_ptr;
    logic [DEPTH_LOG2-1:0]   rd_ptr;
    logic [DEPTH_LOG2:0]     count;
    logic                    do_write;
    logic                    do_read;

    // Handshake on each side
    assign dst_rdy_o = (count != FULL_COUNT);
    assign src_rdy_o = (count != '0);
    assign do_write  = src_rdy_i && dst_rdy_o;
    assign do_read   = src_rdy_o && dst_rdy_i;

    // Head of the buffer is always on the output
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= data_i;
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (arst || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/gpmc_bridge.sv
// Host-to-FPGA half of the processor-bus bridge.
// Host writes land in RAM pages and come out as a framed 18-bit stream.
// The host must give at least two EM_CLK pulses with EM_WE low during arst.

`timescale 1ns/1ns
`include "gpmc_defines.svh"

module gpmc_bridge (
    input  gpmc_pkg::em_data_t    em_d_i,
    input  gpmc_pkg::em_addr_t    em_a_i,
    input  logic                  em_clk_i,
    input  logic                  em_we_i,
    output logic                  have_space_o,
    input  logic                  clk,
    input  logic                  arst,
    input  logic                  clear_i,
    output gpmc_pkg::frame_word_t data_o,
    output logic                  src_rdy_o,
    input  logic                  dst_rdy_i
);

    // Stream between the page emptier and the output FIFO
    gpmc_pkg::frame_word_t page_data;
    logic                  page_src_rdy;
    logic                  page_dst_rdy;

    gpmc_to_fifo page_bridge (
        .em_d_i       (em_d_i),
        .em_a_i       (em_a_i),
        .em_clk_i     (em_clk_i),
        .em_we_i      (em_we_i),
        .clk          (clk),
        .arst         (arst),
        .clear_i      (clear_i),
        .data_o       (page_data),
        .src_rdy_o    (page_src_rdy),
        .dst_rdy_i    (page_dst_rdy),
        .have_space_o (have_space_o)
    );

    // Output buffer keeps the emptier moving over short consumer stalls
    frame_fifo #(
        .DEPTH_LOG2(`GPMC_FIFO_DEPTH_LOG2)
    ) out_fifo (
        .clk       (clk),
        .arst      (arst),
        .clear_i   (clear_i),
        .data_i    (page_data),
        .src_rdy_i (page_src_rdy),
        .dst_rdy_o (page_dst_rdy),
        .data_o    (data_o),
        .src_rdy_o (src_rdy_o),
        .dst_rdy_i (dst_rdy_i)
    );

endmodule

//--- test/tb_gpmc_bridge.sv
// Testbench of the page bridge with a host bus model and stream checks.
// Each host write takes two clk cycles and EM_CLK idles low between writes.
// Frame lengths stay between one unit and a full page.
// Every wait is bounded, and a watchdog ends a run that stalls.

`timescale 1ns/1ns
`include "gpmc_defines.svh"

module tb_gpmc_bridge;

    typedef gpmc_pkg::frame_word_t word_list_t[$];

    logic                  clk;
    logic                  arst;
    logic                  clear;
    gpmc_pkg::em_data_t    em_d;
    gpmc_pkg::em_addr_t    em_a;
    logic                  em_clk;
    logic                  em_we;
    logic                  have_space;
    gpmc_pkg::frame_word_t out_data;
    logic                  out_src_rdy;
    logic                  out_dst_rdy = 1'b0;
    // Consumer mode where 0 stalls, 1 is always ready and 2 is randomly ready
    int                    ready_mode = 0;
    word_list_t            expected_q;
    int                    error_count = 0;
    int                    check_count = 0;
    int                    word_count = 0;
    int                    test_errors = 0;

    gpmc_bridge gpmc_bridge_i (
        .em_d_i       (em_d),
        .em_a_i       (em_a),
        .em_clk_i     (em_clk),
        .em_we_i      (em_we),
        .have_space_o (have_space),
        .clk          (clk),
        .arst         (arst),
        .clear_i      (clear),
        .data_o       (out_data),
        .src_rdy_o    (out_src_rdy),
        .dst_rdy_i    (out_dst_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Stream consumer that is ready about three cycles out of four in random mode
    always @(posedge clk) begin
        case (ready_mode)
            0:       out_dst_rdy <= 1'b0;
            1:       out_dst_rdy <= 1'b1;
            default: out_dst_rdy <= ($urandom_range(3) != 0);
        endcase
    end

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------

    // Length word opens the frame with SOF and the last payload word carries EOF
    function automatic word_list_t expected_frame(input gpmc_pkg::em_data_t len,
                                                  input gpmc_pkg::em_data_t payload[$]);
        word_list_t words;
        words.push_back({2'b01, len});
        for (int i = 0; i < payload.size(); i++)
            words.push_back({(i == payload.size() - 1), 1'b0, payload[i]});
        return words;
    endfunction

    task automatic compare_word(input gpmc_pkg::frame_word_t got,
                                input gpmc_pkg::frame_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL at %0t ns: stream word %05h, expected %05h", $time, got, exp);
        end
    endtask

    task automatic compare_level(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Levels are stable at the falling edge and the word moves on the next rising edge
    always @(negedge clk) begin
        if (!arst && out_src_rdy && out_dst_rdy) begin
            word_count++;
            if (expected_q.size() == 0) begin
                error_count++;
                $display("FAIL at %0t ns: unexpected stream word %05h", $time, out_data);
            end else begin
                compare_word(out_data, expected_q.pop_front());
            end
        end
    end

    // ----------------------------------------
    // Host bus model
    // ----------------------------------------

    task automatic reset_bridge();
        @(posedge clk);
        arst  <= 1'b1;
        em_we <= 1'b0;
        // The EM_CLK domain only sees reset on its own falling edges
        repeat (7) begin
            @(posedge clk);
            em_clk <= 1'b1;
            @(posedge clk);
            em_clk <= 1'b0;
        end
        @(posedge clk);
        arst <= 1'b0;
        expected_q.delete();
    endtask

    // Address and data are set with the rising strobe and held over the falling one
    task automatic write_word(input gpmc_pkg::em_addr_t addr, input gpmc_pkg::em_data_t data);
        @(posedge clk);
        em_a   <= addr;
        em_d   <= data;
        em_we  <= 1'b1;
        em_clk <= 1'b1;
        @(posedge clk);
        em_clk <= 1'b0;
    endtask

    task automatic wait_for_space(input int max_cycles, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < max_cycles) begin
            @(negedge clk);
            seen = have_space;
            n++;
        end
    endtask

    task automatic send_frame(input gpmc_pkg::em_data_t len, input int space_wait,
                              output bit accepted);
        gpmc_pkg::em_data_t payload[$];
        word_list_t         words;
        // Idle first so the space level reflects the last frame's pointers
        repeat (6) @(posedge clk);
        wait_for_space(space_wait, accepted);
        if (accepted) begin
            for (int i = 1; i < 2 * len; i++)
                payload.push_back(gpmc_pkg::em_data_t'($urandom));
            words = expected_frame(len, payload);
            foreach (words[i])
                expected_q.push_back(words[i]);
            write_word(gpmc_pkg::em_addr_t'(`GPMC_XFER_OFFSET), len);
            foreach (payload[i])
                write_word(gpmc_pkg::em_addr_t'(`GPMC_XFER_OFFSET + i + 1), payload[i]);
            @(posedge clk);
            em_we <= 1'b0;
        end
    endtask

    task automatic host_write(input int len);
        bit ok;
        send_frame(gpmc_pkg::em_data_t'(len), 400, ok);
        if (!ok) begin
            error_count++;
            $display("Host gave up at %0t ns: have_space stayed low", $time);
        end
    endtask

    task automatic wait_for_drain(input int max_cycles);
        int n;
        n = 0;
        while (expected_q.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (expected_q.size() != 0) begin
            error_count++;
            $display("Stream stalled at %0t ns: %0d words never arrived",
                     $time, expected_q.size());
        end
    endtask

    task automatic close_test(input string name);
        if (error_count == test_errors)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    task automatic finish_run();
        $display("checks %0d, stream words %0d, errors %0d",
                 check_count, word_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    initial begin
        repeat (60000) @(posedge clk);
        error_count++;
        $display("Watchdog expired at %0t ns, the run did not finish", $time);
        finish_run();
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        bit ok;
        int pages;
        int words_before;
        void'($urandom(22));
        arst   <= 1'b1;
        clear  <= 1'b0;
        em_d   <= '0;
        em_a   <= '0;
        em_clk <= 1'b0;
        em_we  <= 1'b0;
        reset_bridge();
        @(negedge clk);
        compare_level(out_src_rdy, 1'b0, "src_rdy after reset");
        wait_for_space(8, ok);
        compare_level(have_space, 1'b1, "have_space after reset");
        close_test("reset state");

        // Two units make four bus words
        ready_mode <= 1;
        words_before = word_count;
        host_write(2);
        wait_for_drain(500);
        if (word_count - words_before != 4) begin
            error_count++;
            $display("FAIL at %0t ns: %0d words out, expected 4",
                     $time, word_count - words_before);
        end
        close_test("single frame");

        host_write(1);
        host_write(((1 << `GPMC_ADDR_WIDTH) - `GPMC_XFER_OFFSET) / 2);
        wait_for_drain(3000);
        close_test("minimum and page-size frames");

        ready_mode <= 2;
        repeat (8)
            host_write(int'($urandom_range(40, 1)));
        wait_for_drain(4000);
        close_test("random frames with back-pressure");

        // Frames longer than the output FIFO keep every page held while stalled
        ready_mode <= 0;
        pages = 0;
        ok = 1'b1;
        while (ok && pages < 6) begin
            send_frame(20, 100, ok);
            if (ok)
                pages++;
        end
        if (pages != 4) begin
            error_count++;
            $display("FAIL at %0t ns: %0d pages accepted while stalled, expected 4",
                     $time, pages);
        end
        compare_level(have_space, 1'b0, "have_space with all pages held");
        ready_mode <= 2;
        wait_for_drain(2000);
        wait_for_space(10, ok);
        compare_level(have_space, 1'b1, "have_space after draining");
        close_test("page exhaustion");

        // Every page is held behind a stalled consumer before the clear
        ready_mode <= 0;
        repeat (4)
            host_write(20);
        repeat (10) @(posedge clk);
        @(negedge clk);
        compare_level(have_space, 1'b0, "have_space before clear");
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        expected_q.delete();
        @(negedge clk);
        compare_level(out_src_rdy, 1'b0, "src_rdy after clear");
        wait_for_space(10, ok);
        compare_level(have_space, 1'b1, "have_space after clear");
        ready_mode <= 1;
        host_write(3);
        wait_for_drain(500);
        close_test("clear with pending pages");

        finish_run();
    end

endmodule

//--- project.f
+incdir+design
design/gpmc_pkg.sv
design/ram_2port.sv
design/cross_clock_reader.sv
design/gpmc_to_fifo.sv
design/frame_fifo.sv
design/gpmc_bridge.sv
test/tb_gpmc_bridge.sv

//--- Makefile
# Verilator build and run of the page bridge testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_gpmc_bridge
LINT_TOP  ?= gpmc_bridge
SEED      ?= 22
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, the simulator exit code is not trusted
run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
